//--- rtl/pd_i2c_params.svh
`ifndef PD_I2C_PARAMS_SVH
`define PD_I2C_PARAMS_SVH

// ----------------------------------------
// Route register
// ----------------------------------------
`define PD_I2C_CFG_W 6 // {dpdm_swap, cc_swap, mcu_route, slv_route}
`define PD_I2C_CFG_RST 6'h0F // Both agents OFF and no swap

// ----------------------------------------
// Pad side
// ----------------------------------------
`define PD_I2C_NUM_PAIRS 3 // GPIO, CC1/CC2, DP/DM
`define PD_I2C_SYNC_STAGES 2 // Flops on each pad input

`endif

//--- rtl/pd_i2c_pkg.sv
package pd_i2c_pkg;

	// Route code of one I2C agent
	typedef enum logic [1:0] {
		ROUTE_GPIO = 2'd0,
		ROUTE_CC   = 2'd1, // Swappable
		ROUTE_DPDM = 2'd2, // Swappable
		ROUTE_OFF  = 2'd3
	} route_e;

	// Route register layout, MSB first
	typedef struct packed {
		logic   dpdm_swap; // DM carries SDA
		logic   cc_swap; // CC2 carries SDA
		route_e mcu_route;
		route_e slv_route;
	} route_cfg_t;

	// Two open-drain lines where 1 is released
	typedef struct packed {
		logic first; // SDA, GPIO SDA, CC1 or DP
		logic second; // SCL, GPIO SCL, CC2 or DM
	} pad_pair_t;

	localparam int PAIR_GPIO = 0;
	localparam int PAIR_CC   = 1;
	localparam int PAIR_DPDM = 2;

endpackage

//--- rtl/route_sel_if.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

interface route_sel_if;

	logic [`PD_I2C_NUM_PAIRS-1:0] slv_sel; // One-hot or zero by pair index
	logic [`PD_I2C_NUM_PAIRS-1:0] mcu_sel; // One-hot or zero by pair index
	logic                         cc_swap;
	logic                         dpdm_swap;

	// Written by the route register
	modport cfg (
		output slv_sel,
		output mcu_sel,
		output cc_swap,
		output dpdm_swap
	);

	// Read by pad pairs and the input merge
	modport user (
		input slv_sel,
		input mcu_sel,
		input cc_swap,
		input dpdm_swap
	);

endinterface

//--- rtl/i2c_route_cfg.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

module i2c_route_cfg (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_cfg_we, // One-cycle write strobe
	input  pd_i2c_pkg::route_cfg_t i_cfg_wdat,
	input  logic                   i_strtch_en,
	input  logic                   i_stretch_req,
	route_sel_if.cfg               sel,
	output logic                   o_slv_scl_low,
	output logic                   o_cci2c_en,
	output pd_i2c_pkg::route_cfg_t o_cfg
);

	pd_i2c_pkg::route_cfg_t       cfg_q;
	logic [`PD_I2C_NUM_PAIRS-1:0] slv_dec;
	logic [`PD_I2C_NUM_PAIRS-1:0] mcu_dec;

	// Route code to a pair select that is zero for OFF
	function automatic logic [`PD_I2C_NUM_PAIRS-1:0] route_dec(input pd_i2c_pkg::route_e r);
		logic [`PD_I2C_NUM_PAIRS-1:0] dec;
		dec = '0;
		case (r)
			pd_i2c_pkg::ROUTE_GPIO: dec[pd_i2c_pkg::PAIR_GPIO] = 1'b1;
			pd_i2c_pkg::ROUTE_CC:   dec[pd_i2c_pkg::PAIR_CC] = 1'b1;
			pd_i2c_pkg::ROUTE_DPDM: dec[pd_i2c_pkg::PAIR_DPDM] = 1'b1;
			default:                dec = '0;
		endcase
		return dec;
	endfunction

	// ----------------------------------------
	// Route register
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cfg_q <= pd_i2c_pkg::route_cfg_t'(`PD_I2C_CFG_RST);
		end else if (i_cfg_we) begin
			cfg_q <= i_cfg_wdat;
		end
	end

	assign o_cfg = cfg_q;

	// ----------------------------------------
	// Select decode
	// ----------------------------------------
	assign slv_dec = route_dec(cfg_q.slv_route);
	assign mcu_dec = route_dec(cfg_q.mcu_route);

	assign sel.slv_sel   = slv_dec;
	assign sel.mcu_sel   = mcu_dec;
	assign sel.cc_swap   = cfg_q.cc_swap;
	assign sel.dpdm_swap = cfg_q.dpdm_swap;

	assign o_slv_scl_low = i_strtch_en & i_stretch_req; // Slave holds SCL low
	assign o_cci2c_en    = slv_dec[pd_i2c_pkg::PAIR_CC] |
		mcu_dec[pd_i2c_pkg::PAIR_CC]; // CC pins in I2C mode

endmodule

//--- rtl/i2c_pad_pair.sv
`timescale 1ns/1ps

module i2c_pad_pair #(
	parameter int PAIR_IDX = 0 // 0 GPIO, 1 CC, 2 DP/DM
) (
	route_sel_if.user              sel,
	input  pd_i2c_pkg::pad_pair_t  i_slv, // Only SDA as SCL comes from the hold
	input  logic                   i_slv_scl_low,
	input  pd_i2c_pkg::pad_pair_t  i_mcu,
	output pd_i2c_pkg::pad_pair_t  o_pad
);

	logic slv_on; // Slave routed here
	logic mcu_on; // Master routed here
	logic sda_low;
	logic scl_low;
	logic swap;

	assign slv_on = sel.slv_sel[PAIR_IDX];
	assign mcu_on = sel.mcu_sel[PAIR_IDX];

	// ----------------------------------------
	// Wired-AND of both agents
	// ----------------------------------------
	always_comb begin
		sda_low = (slv_on & ~i_slv.first) | (mcu_on & ~i_mcu.first);
		scl_low = (slv_on & i_slv_scl_low) | (mcu_on & ~i_mcu.second);
	end

	// ----------------------------------------
	// Swap bit of this pair
	// ----------------------------------------
	generate
		if (PAIR_IDX == pd_i2c_pkg::PAIR_CC) begin : g_swap_cc
			assign swap = sel.cc_swap;
		end else if (PAIR_IDX == pd_i2c_pkg::PAIR_DPDM) begin : g_swap_dpdm
			assign swap = sel.dpdm_swap;
		end else begin : g_swap_none
			assign swap = 1'b0; // GPIO pair is fixed
		end
	endgenerate

	// Open-drain levels toward the pads
	always_comb begin
		if (swap) begin
			o_pad.first  = ~scl_low; // CC1 or DP carries SCL
			o_pad.second = ~sda_low;
		end else begin
			o_pad.first  = ~sda_low;
			o_pad.second = ~scl_low;
		end
	end

endmodule

//--- rtl/i2c_in_merge.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

module i2c_in_merge (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  pd_i2c_pkg::pad_pair_t i_gpio_pad,
	input  pd_i2c_pkg::pad_pair_t i_cc_pad,
	input  pd_i2c_pkg::pad_pair_t i_dpdm_pad,
	route_sel_if.user             sel,
	output pd_i2c_pkg::pad_pair_t o_slv_in,
	output pd_i2c_pkg::pad_pair_t o_mcu_in
);

	localparam int NS = `PD_I2C_SYNC_STAGES;
	localparam int NP = `PD_I2C_NUM_PAIRS;

	pd_i2c_pkg::pad_pair_t [NP-1:0] pad_raw; // Indexed by pair
	pd_i2c_pkg::pad_pair_t [NP-1:0] sync_q [NS];
	pd_i2c_pkg::pad_pair_t [NP-1:0] pair_in; // SDA in first after unswap
	logic                           slv_sda_low;
	logic                           slv_scl_low;
	logic                           mcu_sda_low;
	logic                           mcu_scl_low;

	assign pad_raw[pd_i2c_pkg::PAIR_GPIO] = i_gpio_pad;
	assign pad_raw[pd_i2c_pkg::PAIR_CC]   = i_cc_pad;
	assign pad_raw[pd_i2c_pkg::PAIR_DPDM] = i_dpdm_pad;

	// ----------------------------------------
	// Pad synchronizers
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < NS; i++) begin
				sync_q[i] <= '1; // Lines released
			end
		end else begin
			sync_q[0] <= pad_raw;
			for (int i = 1; i < NS; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Undo the swap on CC and DP/DM
	always_comb begin
		pair_in = sync_q[NS-1];
		if (sel.cc_swap) begin
			pair_in[pd_i2c_pkg::PAIR_CC].first  = sync_q[NS-1][pd_i2c_pkg::PAIR_CC].second;
			pair_in[pd_i2c_pkg::PAIR_CC].second = sync_q[NS-1][pd_i2c_pkg::PAIR_CC].first;
		end
		if (sel.dpdm_swap) begin
			pair_in[pd_i2c_pkg::PAIR_DPDM].first  = sync_q[NS-1][pd_i2c_pkg::PAIR_DPDM].second;
			pair_in[pd_i2c_pkg::PAIR_DPDM].second = sync_q[NS-1][pd_i2c_pkg::PAIR_DPDM].first;
		end
	end

	// ----------------------------------------
	// Per-agent wired-AND
	// ----------------------------------------
	always_comb begin
		slv_sda_low = 1'b0;
		slv_scl_low = 1'b0;
		mcu_sda_low = 1'b0;
		mcu_scl_low = 1'b0;
		for (int k = 0; k < NP; k++) begin
			slv_sda_low |= sel.slv_sel[k] & ~pair_in[k].first;
			slv_scl_low |= sel.slv_sel[k] & ~pair_in[k].second;
			mcu_sda_low |= sel.mcu_sel[k] & ~pair_in[k].first;
			mcu_scl_low |= sel.mcu_sel[k] & ~pair_in[k].second;
		end
	end

	assign o_slv_in.first  = ~slv_sda_low; // Released when unrouted
	assign o_slv_in.second = ~slv_scl_low;
	assign o_mcu_in.first  = ~mcu_sda_low;
	assign o_mcu_in.second = ~mcu_scl_low;

endmodule

//--- rtl/pd_i2c_router.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

module pd_i2c_router (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  logic                     i_cfg_we,
	input  logic [`PD_I2C_CFG_W-1:0] i_cfg_wdat,
	input  logic                     i_strtch_en, // Stretch allowed
	input  logic                     i_stretch_req, // Slave engine wants SCL held
	input  logic                     i_slv_sda_o,
	input  logic                     i_mcu_sda_o,
	input  logic                     i_mcu_scl_o,
	input  logic                     i_gpio_sda,
	input  logic                     i_gpio_scl,
	input  logic                     i_cc1,
	input  logic                     i_cc2,
	input  logic                     i_dp,
	input  logic                     i_dm,
	output logic                     o_gpio_sda,
	output logic                     o_gpio_scl,
	output logic                     o_cc1,
	output logic                     o_cc2,
	output logic                     o_dp,
	output logic                     o_dm,
	output logic                     o_slv_sda_i,
	output logic                     o_slv_scl_i,
	output logic                     o_mcu_sda_i,
	output logic                     o_mcu_scl_i,
	output logic                     o_cci2c_en,
	output logic [`PD_I2C_CFG_W-1:0] o_cfg
);

	pd_i2c_pkg::route_cfg_t cfg_wdat;
	pd_i2c_pkg::route_cfg_t cfg_q;
	pd_i2c_pkg::pad_pair_t  slv_drv; // SCL field unused
	pd_i2c_pkg::pad_pair_t  mcu_drv;
	pd_i2c_pkg::pad_pair_t  gpio_do, cc_do, dpdm_do;
	pd_i2c_pkg::pad_pair_t  gpio_di, cc_di, dpdm_di;
	pd_i2c_pkg::pad_pair_t  slv_in, mcu_in;
	logic                   slv_scl_low;

	route_sel_if u_sel ();

	assign cfg_wdat = pd_i2c_pkg::route_cfg_t'(i_cfg_wdat);
	assign o_cfg    = cfg_q;

	assign slv_drv = '{first: i_slv_sda_o, second: 1'b1};
	assign mcu_drv = '{first: i_mcu_sda_o, second: i_mcu_scl_o};
	assign gpio_di = '{first: i_gpio_sda, second: i_gpio_scl};
	assign cc_di   = '{first: i_cc1, second: i_cc2};
	assign dpdm_di = '{first: i_dp, second: i_dm};

	i2c_route_cfg u_route_cfg (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_cfg_we      (i_cfg_we),
		.i_cfg_wdat    (cfg_wdat),
		.i_strtch_en   (i_strtch_en),
		.i_stretch_req (i_stretch_req),
		.sel           (u_sel.cfg),
		.o_slv_scl_low (slv_scl_low),
		.o_cci2c_en    (o_cci2c_en),
		.o_cfg         (cfg_q)
	);

	// ----------------------------------------
	// Toward the pads
	// ----------------------------------------
	i2c_pad_pair #(.PAIR_IDX(pd_i2c_pkg::PAIR_GPIO)) u_pair_gpio (
		.sel (u_sel.user), .i_slv (slv_drv), .i_slv_scl_low (slv_scl_low),
		.i_mcu (mcu_drv), .o_pad (gpio_do)
	);
	i2c_pad_pair #(.PAIR_IDX(pd_i2c_pkg::PAIR_CC)) u_pair_cc (
		.sel (u_sel.user), .i_slv (slv_drv), .i_slv_scl_low (slv_scl_low),
		.i_mcu (mcu_drv), .o_pad (cc_do)
	);
	i2c_pad_pair #(.PAIR_IDX(pd_i2c_pkg::PAIR_DPDM)) u_pair_dpdm (
		.sel (u_sel.user), .i_slv (slv_drv), .i_slv_scl_low (slv_scl_low),
		.i_mcu (mcu_drv), .o_pad (dpdm_do)
	);

	assign {o_gpio_sda, o_gpio_scl} = gpio_do;
	assign {o_cc1, o_cc2}           = cc_do;
	assign {o_dp, o_dm}             = dpdm_do;

	// ----------------------------------------
	// Back from the pads
	// ----------------------------------------
	i2c_in_merge u_in_merge (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_gpio_pad (gpio_di),
		.i_cc_pad   (cc_di),
		.i_dpdm_pad (dpdm_di),
		.sel        (u_sel.user),
		.o_slv_in   (slv_in),
		.o_mcu_in   (mcu_in)
	);

	assign {o_slv_sda_i, o_slv_scl_i} = slv_in;
	assign {o_mcu_sda_i, o_mcu_scl_i} = mcu_in;

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter real HALF_NS    = 2.0, // 4 ns period
	parameter int  RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_NS) o_clk = ~o_clk;
	end

	initial begin
		o_arst_n = 1'b0;
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge o_clk);
		end
		#1 o_arst_n = 1'b1; // Released off the edge
	end

endmodule

//--- tb/pd_i2c_router_chk.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

module pd_i2c_router_chk (
	input logic                     i_clk,
	input logic                     i_arst_n,
	input logic                     i_cfg_we,
	input logic [`PD_I2C_CFG_W-1:0] i_cfg_wdat,
	input logic [`PD_I2C_CFG_W-1:0] i_cfg,
	input logic                     i_cci2c_en,
	input logic [5:0]               i_pads // {gpio_sda, gpio_scl, cc1, cc2, dp, dm}
);

	pd_i2c_pkg::route_cfg_t cfg;
	logic                   both_off;
	logic                   some_cc;

	assign cfg      = pd_i2c_pkg::route_cfg_t'(i_cfg);
	assign both_off = (cfg.slv_route == pd_i2c_pkg::ROUTE_OFF) &&
		(cfg.mcu_route == pd_i2c_pkg::ROUTE_OFF);
	assign some_cc  = (cfg.slv_route == pd_i2c_pkg::ROUTE_CC) ||
		(cfg.mcu_route == pd_i2c_pkg::ROUTE_CC);

	// ----------------------------------------
	// Properties
	// ----------------------------------------
	a_off_released: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		both_off |-> (i_pads == 6'h3F))
		else $error("pad line low while both routes are OFF");

	a_cc_mode: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_cci2c_en == some_cc)
		else $error("o_cci2c_en disagrees with the CC routes");

	a_cfg_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_cfg_we |=> (i_cfg == $past(i_cfg_wdat)))
		else $error("o_cfg missed the written word");

endmodule

//--- tb/tb_pd_i2c_router.sv
`timescale 1ns/1ps
`include "pd_i2c_params.svh"

module tb_pd_i2c_router;

	localparam int WAIT_LIMIT = 16; // Cycles before a wait gives up

	logic                     clk;
	logic                     arst_n;
	logic                     cfg_we;
	logic [`PD_I2C_CFG_W-1:0] cfg_wdat;
	logic [`PD_I2C_CFG_W-1:0] cfg;
	logic                     strtch_en;
	logic                     stretch_req;
	logic                     slv_sda_o;
	logic                     mcu_sda_o;
	logic                     mcu_scl_o;
	logic [5:0]               pad_in; // {gpio_sda, gpio_scl, cc1, cc2, dp, dm}
	logic [5:0]               pad_out; // Same order
	logic [3:0]               agent_in; // {slv_sda, slv_scl, mcu_sda, mcu_scl}
	logic                     cci2c_en;
	int                       errors;
	int                       tests;
	int                       test_err;
	int                       fd;
	bit                       timed_out;
	logic [31:0]              rng;

	tb_clkgen u_clkgen (.o_clk(clk), .o_arst_n(arst_n));

	pd_i2c_router dut (
		.i_clk (clk), .i_arst_n (arst_n), .i_cfg_we (cfg_we), .i_cfg_wdat (cfg_wdat),
		.i_strtch_en (strtch_en), .i_stretch_req (stretch_req),
		.i_slv_sda_o (slv_sda_o), .i_mcu_sda_o (mcu_sda_o), .i_mcu_scl_o (mcu_scl_o),
		.i_gpio_sda (pad_in[5]), .i_gpio_scl (pad_in[4]), .i_cc1 (pad_in[3]),
		.i_cc2 (pad_in[2]), .i_dp (pad_in[1]), .i_dm (pad_in[0]),
		.o_gpio_sda (pad_out[5]), .o_gpio_scl (pad_out[4]), .o_cc1 (pad_out[3]),
		.o_cc2 (pad_out[2]), .o_dp (pad_out[1]), .o_dm (pad_out[0]),
		.o_slv_sda_i (agent_in[3]), .o_slv_scl_i (agent_in[2]),
		.o_mcu_sda_i (agent_in[1]), .o_mcu_scl_i (agent_in[0]),
		.o_cci2c_en (cci2c_en), .o_cfg (cfg)
	);

	bind pd_i2c_router pd_i2c_router_chk u_chk (
		.i_clk (i_clk), .i_arst_n (i_arst_n), .i_cfg_we (i_cfg_we),
		.i_cfg_wdat (i_cfg_wdat), .i_cfg (o_cfg), .i_cci2c_en (o_cci2c_en),
		.i_pads ({o_gpio_sda, o_gpio_scl, o_cc1, o_cc2, o_dp, o_dm})
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Open-drain wired-AND of both agents on one pair
	function automatic logic [5:0] shared_pads(input logic [5:0] c, input logic [2:0] d,
		input logic [1:0] s);
		logic sda;
		logic scl;
		sda = d[2] & d[1];
		scl = ~(s[1] & s[0]) & d[0]; // Stretch hold or master SCL
		case (c[1:0])
			2'd0:    return {sda, scl, 4'hF};
			2'd1:    return {2'b11, (c[4] ? {scl, sda} : {sda, scl}), 2'b11};
			default: return {4'hF, (c[5] ? {scl, sda} : {sda, scl})};
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic finish_test(input int id, input string name);
		tests++;
		errors += test_err;
		$display("test %0d %s: %0d mismatches", id, name, test_err);
		test_err = 0;
	endtask

	task automatic apply(input logic [5:0] c, input logic [2:0] d, input logic [1:0] s,
		input logic [5:0] pads);
		cfg_we                             = 1'b1;
		cfg_wdat                           = c;
		{slv_sda_o, mcu_sda_o, mcu_scl_o}  = d;
		{strtch_en, stretch_req}           = s;
		pad_in                             = pads;
	endtask

	// Write strobe stays up until o_cfg shows the word
	task automatic wait_cfg(input logic [5:0] c, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (cfg !== c && cycles < WAIT_LIMIT);
		cfg_we = 1'b0;
		if (cfg !== c) begin
			$display("Timeout: o_cfg never showed the written word %h", c);
			timed_out = 1'b1;
			test_err++;
		end
	endtask

	task automatic wait_edges(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		string       line;
		logic [31:0] id, c, drv, str, pads, exp_pad, exp_ag, exp_cc;
		int          cycles;
		int          n;
		int          pair;
		logic [5:0]  rc;
		cfg_we      = 1'b0;
		cfg_wdat    = `PD_I2C_CFG_RST;
		strtch_en   = 1'b1; // Agents and pads pulled low while routes are OFF
		stretch_req = 1'b1;
		slv_sda_o   = 1'b0;
		mcu_sda_o   = 1'b0;
		mcu_scl_o   = 1'b0;
		pad_in      = 6'h00;
		errors      = 0;
		tests       = 0;
		test_err    = 0;
		timed_out   = 1'b0;

		// ----------------------------------------
		// Reset state
		// ----------------------------------------
		cycles = 0;
		while (arst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		#1;
		if (arst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
			test_err++;
		end
		check("o_cfg", cfg, `PD_I2C_CFG_RST);
		check("pad_out", pad_out, 6'h3F);
		check("o_cci2c_en", cci2c_en, 1'b0);
		cycles = 0;
		while (agent_in !== 4'hF && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (agent_in !== 4'hF) begin
			$display("Timeout: agent inputs stayed low after reset");
			timed_out = 1'b1;
		end
		check("agent_in", agent_in, 4'hF);
		finish_test(0, "reset");

		// ----------------------------------------
		// Golden vectors
		// ----------------------------------------
		fd = $fopen("tb/router_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/router_golden.txt");
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd)) begin
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				n = $sscanf(line, "%h %h %h %h %h %h %h %h", id, c, drv, str, pads,
					exp_pad, exp_ag, exp_cc);
				if (n != 8) begin
					$display("Golden file line has %0d fields instead of 8: %s", n, line);
					errors++;
					continue;
				end
				apply(c[5:0], drv[2:0], str[1:0], pads[5:0]);
				wait_cfg(c[5:0], cycles);
				check("o_cfg latency", cycles, 1);
				check("o_cfg", cfg, c);
				check("pad_out", pad_out, exp_pad);
				check("o_cci2c_en", cci2c_en, exp_cc);
				wait_edges(1); // Second synchronizer edge
				check("agent_in", agent_in, exp_ag);
				finish_test(id, "golden");
			end
			$fclose(fd);
		end

		// ----------------------------------------
		// Shared pair, random drives
		// ----------------------------------------
		rng = 32'he5d54b7b;
		for (int i = 0; i < 16 && !timed_out; i++) begin
			rng  = xorshift(rng);
			pair = rng[15:8] % 3;
			rc   = {rng[1:0], pair[1:0], pair[1:0]};
			apply(rc, rng[4:2], rng[6:5], 6'h3F);
			wait_cfg(rc, cycles);
			check("o_cfg", cfg, rc);
			check("pad_out", pad_out, shared_pads(rc, rng[4:2], rng[6:5]));
			finish_test(100 + i, "shared");
		end

		// ----------------------------------------
		// Pad input latency
		// ----------------------------------------
		if (!timed_out) begin
			pad_in = 6'h00; // Both agents share one pair here
			wait_edges(1);
			check("agent_in", agent_in, 4'hF); // Old samples still in flight
			wait_edges(1);
			check("agent_in", agent_in, 4'h0);
			finish_test(200, "input latency");
		end

		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- tb/router_golden.txt
# id cfg drv{slv_sda,mcu_sda,mcu_scl} str{strtch_en,stretch_req} pad_in exp_pad exp_agent exp_cci2c
# pad bits {gpio_sda,gpio_scl,cc1,cc2,dp,dm}, agent bits {slv_sda,slv_scl,mcu_sda,mcu_scl}
# all fields hex, 1 is a released line
01 0F 0 3 00 3F F 0
02 0C 3 0 1F 1F 7 0
03 03 6 0 2F 2F E 0
04 0D 3 0 37 37 7 1
05 1D 3 0 3B 3B 7 1
06 17 5 3 37 3B E 1
07 0E 3 3 3E 3C B 0
08 2E 7 3 3D 3D B 0
09 28 6 0 1E 3D 5 0
0A 0C 7 2 3F 3F F 0
0B 0C 7 1 3F 3F F 0
0C 0C 7 3 3F 2F F 0
0D 1D 7 3 3F 37 F 1
0E 00 5 3 2F 0F A 0
0F 05 3 0 33 37 0 1
10 18 0 0 31 1C D 0
11 31 2 0 14 2B 9 1
12 0F 0 3 00 3F F 0
13 26 4 3 0B 31 E 1
14 2A 3 0 3D 3E A 0

//--- sources.f
+incdir+rtl
rtl/pd_i2c_pkg.sv
rtl/route_sel_if.sv
rtl/i2c_route_cfg.sv
rtl/i2c_pad_pair.sv
rtl/i2c_in_merge.sv
rtl/pd_i2c_router.sv
tb/tb_clkgen.sv
tb/pd_i2c_router_chk.sv
tb/tb_pd_i2c_router.sv

//--- Bender.yml
package:
  name: pd_i2c_router

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pd_i2c_pkg.sv
      - rtl/route_sel_if.sv
      - rtl/i2c_route_cfg.sv
      - rtl/i2c_pad_pair.sv
      - rtl/i2c_in_merge.sv
      - rtl/pd_i2c_router.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clkgen.sv
      - tb/pd_i2c_router_chk.sv
      - tb/tb_pd_i2c_router.sv
